// ==== verilog/bridge_config.svh ====
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Physical address width on both the cache side and AXI
`define BRIDGE_ADDR_W 32

// Words per cache line, one AXI beat each
`define BRIDGE_LINE_WORDS 4

// AXI ID field width and the per-port IDs
`define BRIDGE_ID_W 4
`define BRIDGE_ID_INST 4'd0
`define BRIDGE_ID_DATA 4'd1

// Transfer type codes from the cache side
`define BRIDGE_TYPE_BYTE 3'd0
`define BRIDGE_TYPE_HALF 3'd1
`define BRIDGE_TYPE_WORD 3'd2
`define BRIDGE_TYPE_LINE 3'd4

`endif

// ==== verilog/bridge_pkg.sv ====
`include "bridge_config.svh"

package bridge_pkg;

    // Cache read request
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0]       addr;
        logic [2:0]                      xfer_type;
    } cache_rd_req_t;

    // Cache write request, single word sits in data[31:0]
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0]       addr;
        logic [2:0]                      xfer_type;
        logic [3:0]                      strb;
        logic [32*`BRIDGE_LINE_WORDS-1:0] data;
    } cache_wr_req_t;

    // One returned beat toward a cache
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } cache_ret_t;

    // Address channel, shared by AR and AW
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
    } axi_ar_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] id;
        logic [31:0]             data;
        logic [1:0]              resp;
        logic                    last;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] id;
        logic [1:0]              resp;
    } axi_b_t;

    // Burst length minus one for a transfer type
    function automatic logic [7:0] xfer_len(input logic [2:0] xfer_type);
        return (xfer_type == `BRIDGE_TYPE_LINE) ? 8'(`BRIDGE_LINE_WORDS - 1) : 8'd0;
    endfunction

    // Bytes per beat as log2
    function automatic logic [2:0] xfer_size(input logic [2:0] xfer_type);
        case (xfer_type)
            `BRIDGE_TYPE_BYTE: return 3'd0;
            `BRIDGE_TYPE_HALF: return 3'd1;
            default:           return 3'd2; // WORD and LINE
        endcase
    endfunction

endpackage

// ==== verilog/ar_arbiter.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module ar_arbiter (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Cache read ports
    input  logic                      inst_rd_req,
    input  bridge_pkg::cache_rd_req_t inst_rd,
    output logic                      inst_rd_rdy,
    input  logic                      data_rd_req,
    input  bridge_pkg::cache_rd_req_t data_rd,
    output logic                      data_rd_rdy,
    // Outstanding tracking in r_router
    input  logic                      inst_busy,
    input  logic                      data_busy,
    output logic                      inst_issue,
    output logic                      data_issue,
    // Write hazard from w_burst_engine
    input  logic                      wr_pending,
    input  logic [`BRIDGE_ADDR_W-1:0] wr_line,
    // AR channel
    output logic                      arvalid,
    output bridge_pkg::axi_ar_t       ar,
    input  logic                      arready
);

    logic                      data_hazard;
    logic                      data_take;
    logic                      inst_take;
    bridge_pkg::cache_rd_req_t sel_rd;

    // Read of a line whose write has not seen B yet
    assign data_hazard = wr_pending &&
        (data_rd.addr[`BRIDGE_ADDR_W-1:4] == wr_line[`BRIDGE_ADDR_W-1:4]);

    assign data_rd_rdy = !arvalid && !data_busy && !data_hazard;
    assign data_take   = data_rd_req && data_rd_rdy;

    // Inst port backs off when data grabs the AR slot
    assign inst_rd_rdy = !arvalid && !inst_busy && !data_take;
    assign inst_take   = inst_rd_req && inst_rd_rdy;

    assign data_issue = data_take;  // Marks data busy next cycle
    assign inst_issue = inst_take;

    assign sel_rd = data_take ? data_rd : inst_rd;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (data_take || inst_take) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    // AR payload, loaded only while the slot is empty
    always_ff @(posedge aclk) begin
        if (data_take || inst_take) begin
            ar.id   <= data_take ? `BRIDGE_ID_DATA : `BRIDGE_ID_INST;
            ar.addr <= sel_rd.addr;
            ar.len  <= bridge_pkg::xfer_len(sel_rd.xfer_type);
            ar.size <= bridge_pkg::xfer_size(sel_rd.xfer_type);
        end
    end

endmodule

// ==== verilog/r_router.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module r_router (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Issue pulses from ar_arbiter
    input  logic                   inst_issue,
    input  logic                   data_issue,
    output logic                   inst_busy,
    output logic                   data_busy,
    // R channel
    input  logic                   rvalid,
    input  bridge_pkg::axi_r_t     r,
    output logic                   rready,
    // Return ports
    output logic                   inst_ret_valid,
    output bridge_pkg::cache_ret_t inst_ret,
    output logic                   data_ret_valid,
    output bridge_pkg::cache_ret_t data_ret
);

    logic r_is_inst;
    logic r_is_data;

    assign r_is_inst = (r.id == `BRIDGE_ID_INST);
    assign r_is_data = (r.id == `BRIDGE_ID_DATA);

    assign rready = inst_busy || data_busy;

    // Beats go straight through, the cache cannot stall them
    assign inst_ret_valid = rvalid && inst_busy && r_is_inst;
    assign data_ret_valid = rvalid && data_busy && r_is_data;

    assign inst_ret = '{data: r.data, last: r.last};
    assign data_ret = '{data: r.data, last: r.last};

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (inst_issue) begin
                inst_busy <= 1'b1;
            end else if (inst_ret_valid && r.last) begin
                inst_busy <= 1'b0;  // Final beat frees the slot
            end
            if (data_issue) begin
                data_busy <= 1'b1;
            end else if (data_ret_valid && r.last) begin
                data_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/w_burst_engine.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module w_burst_engine (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Data cache write port
    input  logic                      data_wr_req,
    input  bridge_pkg::cache_wr_req_t data_wr,
    output logic                      data_wr_rdy,
    // Hazard info toward ar_arbiter
    output logic                      wr_pending,
    output logic [`BRIDGE_ADDR_W-1:0] wr_line,
    // AW channel
    output logic                      awvalid,
    output bridge_pkg::axi_ar_t       aw,
    input  logic                      awready,
    // W channel
    output logic                      wvalid,
    output bridge_pkg::axi_w_t        w,
    input  logic                      wready,
    // B channel
    input  logic                      bvalid,
    input  bridge_pkg::axi_b_t        b,
    output logic                      bready
);

    localparam int BEAT_W = $clog2(`BRIDGE_LINE_WORDS);

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data,
        s_resp
    } w_state_t;

    w_state_t                  state;
    logic [BEAT_W-1:0]         beat_cnt;
    logic [BEAT_W-1:0]         last_beat;
    logic                      is_line;
    logic                      wr_take;
    bridge_pkg::cache_wr_req_t wr_buf;

    assign data_wr_rdy = (state == s_idle);
    assign wr_take     = data_wr_req && data_wr_rdy;

    // Hazard also covers the acceptance cycle itself
    assign wr_pending = !data_wr_rdy || wr_take;
    assign wr_line    = data_wr_rdy ? data_wr.addr : wr_buf.addr;

    assign is_line   = (wr_buf.xfer_type == `BRIDGE_TYPE_LINE);
    assign last_beat = BEAT_W'(bridge_pkg::xfer_len(wr_buf.xfer_type));

    assign awvalid = (state == s_addr);
    assign aw = '{
        id:   `BRIDGE_ID_DATA,
        addr: wr_buf.addr,
        len:  bridge_pkg::xfer_len(wr_buf.xfer_type),
        size: bridge_pkg::xfer_size(wr_buf.xfer_type)
    };

    assign wvalid = (state == s_data);
    assign w = '{
        data: wr_buf.data[beat_cnt*32 +: 32],     // Beat slice of the line
        strb: is_line ? 4'b1111 : wr_buf.strb,
        last: (beat_cnt == last_beat)
    };

    assign bready = (state == s_resp);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= s_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (data_wr_req) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    if (awready) begin
                        state    <= s_data;
                        beat_cnt <= '0;
                    end
                end
                s_data: begin
                    if (wready) begin
                        if (beat_cnt == last_beat) begin
                            state <= s_resp;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                s_resp: begin
                    if (bvalid && b.id == `BRIDGE_ID_DATA) begin
                        state <= s_idle;  // wr_rdy back next cycle
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Request held for the whole burst
    always_ff @(posedge aclk) begin
        if (wr_take) begin
            wr_buf <= data_wr;
        end
    end

endmodule

// ==== verilog/cache_axi_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module cache_axi_bridge (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Instruction cache read port
    input  logic                      inst_rd_req,
    input  bridge_pkg::cache_rd_req_t inst_rd,
    output logic                      inst_rd_rdy,
    output logic                      inst_ret_valid,
    output bridge_pkg::cache_ret_t    inst_ret,
    // Data cache read port
    input  logic                      data_rd_req,
    input  bridge_pkg::cache_rd_req_t data_rd,
    output logic                      data_rd_rdy,
    output logic                      data_ret_valid,
    output bridge_pkg::cache_ret_t    data_ret,
    // Data cache write port
    input  logic                      data_wr_req,
    input  bridge_pkg::cache_wr_req_t data_wr,
    output logic                      data_wr_rdy,
    // AR
    output logic                      arvalid,
    output bridge_pkg::axi_ar_t       ar,
    input  logic                      arready,
    // R
    input  logic                      rvalid,
    input  bridge_pkg::axi_r_t        r,
    output logic                      rready,
    // AW
    output logic                      awvalid,
    output bridge_pkg::axi_ar_t       aw,
    input  logic                      awready,
    // W
    output logic                      wvalid,
    output bridge_pkg::axi_w_t        w,
    input  logic                      wready,
    // B
    input  logic                      bvalid,
    input  bridge_pkg::axi_b_t        b,
    output logic                      bready
);

    logic                      inst_busy;   // Per-port read in flight
    logic                      data_busy;
    logic                      inst_issue;
    logic                      data_issue;
    logic                      wr_pending;  // Write taken, B not yet seen
    logic [`BRIDGE_ADDR_W-1:0] wr_line;

    ar_arbiter u_ar_arbiter (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .inst_rd_req (inst_rd_req),
        .inst_rd     (inst_rd),
        .inst_rd_rdy (inst_rd_rdy),
        .data_rd_req (data_rd_req),
        .data_rd     (data_rd),
        .data_rd_rdy (data_rd_rdy),
        .inst_busy   (inst_busy),
        .data_busy   (data_busy),
        .inst_issue  (inst_issue),
        .data_issue  (data_issue),
        .wr_pending  (wr_pending),
        .wr_line     (wr_line),
        .arvalid     (arvalid),
        .ar          (ar),
        .arready     (arready)
    );

    r_router u_r_router (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .inst_issue     (inst_issue),
        .data_issue     (data_issue),
        .inst_busy      (inst_busy),
        .data_busy      (data_busy),
        .rvalid         (rvalid),
        .r              (r),
        .rready         (rready),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret       (inst_ret),
        .data_ret_valid (data_ret_valid),
        .data_ret       (data_ret)
    );

    w_burst_engine u_w_burst_engine (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .data_wr_req (data_wr_req),
        .data_wr     (data_wr),
        .data_wr_rdy (data_wr_rdy),
        .wr_pending  (wr_pending),
        .wr_line     (wr_line),
        .awvalid     (awvalid),
        .aw          (aw),
        .awready     (awready),
        .wvalid      (wvalid),
        .w           (w),
        .wready      (wready),
        .bvalid      (bvalid),
        .b           (b),
        .bready      (bready)
    );

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_mem_model (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                arvalid,
    input  bridge_pkg::axi_ar_t ar,
    output logic                arready,
    output logic                rvalid,
    output bridge_pkg::axi_r_t  r,
    input  logic                rready,
    input  logic                awvalid,
    input  bridge_pkg::axi_ar_t aw,
    output logic                awready,
    input  logic                wvalid,
    input  bridge_pkg::axi_w_t  w,
    output logic                wready,
    output logic                bvalid,
    output bridge_pkg::axi_b_t  b,
    input  logic                bready
);

    logic [31:0] mem [0:1023];  // 4 KB, word indexed
    bridge_pkg::axi_ar_t rd_cmd;
    bridge_pkg::axi_ar_t wr_cmd;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 32'h0100_0193) ^ 32'hc0de_0000;
        end
    end

    // Read side, one burst at a time
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge aclk);
            if (rst_n && arvalid) begin
                repeat ($urandom_range(0, 3)) @(negedge aclk);
                arready = 1'b1;
                @(posedge aclk);
                rd_cmd = ar;
                @(negedge aclk);
                arready = 1'b0;
                for (int i = 0; i <= int'(rd_cmd.len); i++) begin
                    repeat ($urandom_range(0, 3)) @(negedge aclk);
                    rvalid = 1'b1;
                    r = '{id: rd_cmd.id, data: mem[rd_cmd.addr[11:2] + 10'(i)],
                          resp: 2'b00, last: (i == int'(rd_cmd.len))};
                    do @(posedge aclk); while (!rready);
                    @(negedge aclk);
                    rvalid = 1'b0;
                end
            end
        end
    end

    // Write side, memory updated per W beat before B
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        forever begin
            @(negedge aclk);
            if (rst_n && awvalid) begin
                repeat ($urandom_range(0, 3)) @(negedge aclk);
                awready = 1'b1;
                @(posedge aclk);
                wr_cmd = aw;
                @(negedge aclk);
                awready = 1'b0;
                for (int i = 0; i <= int'(wr_cmd.len); i++) begin
                    repeat ($urandom_range(0, 3)) @(negedge aclk);
                    wready = 1'b1;
                    do @(posedge aclk); while (!wvalid);
                    for (int k = 0; k < 4; k++) begin
                        if (w.strb[k]) begin
                            mem[wr_cmd.addr[11:2] + 10'(i)][k*8 +: 8] = w.data[k*8 +: 8];
                        end
                    end
                    @(negedge aclk);
                    wready = 1'b0;
                end
                repeat ($urandom_range(0, 3)) @(negedge aclk);
                bvalid = 1'b1;
                b = '{id: wr_cmd.id, resp: 2'b00};
                do @(posedge aclk); while (!bready);
                @(negedge aclk);
                bvalid = 1'b0;
            end
        end
    end

endmodule

// ==== bench/tb_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_bridge;

    localparam int MAX_CYCLES = 4000;

    logic aclk;
    logic rst_n;
    logic inst_rd_req, inst_rd_rdy, inst_ret_valid;
    logic data_rd_req, data_rd_rdy, data_ret_valid;
    logic data_wr_req, data_wr_rdy;
    bridge_pkg::cache_rd_req_t inst_rd, data_rd;
    bridge_pkg::cache_ret_t    inst_ret, data_ret;
    bridge_pkg::cache_wr_req_t data_wr;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready;
    bridge_pkg::axi_ar_t ar, aw;
    bridge_pkg::axi_r_t  r;
    bridge_pkg::axi_w_t  w;
    bridge_pkg::axi_b_t  b;

    logic [31:0] shadow [0:1023];
    bridge_pkg::cache_ret_t exp_inst[$];
    bridge_pkg::cache_ret_t exp_data[$];
    bridge_pkg::axi_ar_t    exp_ar[$];
    bridge_pkg::axi_ar_t    exp_aw[$];
    logic [7:0] w_len = '0;   // Length of the burst on W
    int         w_beat = 0;
    int errors = 0;
    int cycles = 0;

    cache_axi_bridge u_dut (.*);

    axi_mem_model u_mem (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // Expected word at a byte address
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[addr[11:2]];
    endfunction

    // Address beat the bridge should send for a request
    function automatic bridge_pkg::axi_ar_t ref_addr(input logic [`BRIDGE_ID_W-1:0] id,
                                                     input logic [31:0] addr,
                                                     input logic [2:0] xfer);
        bridge_pkg::axi_ar_t a;
        a.id   = id;
        a.addr = addr;
        a.len  = (xfer == `BRIDGE_TYPE_LINE) ? 8'd3 : 8'd0;
        case (xfer)
            `BRIDGE_TYPE_BYTE: a.size = 3'd0;
            `BRIDGE_TYPE_HALF: a.size = 3'd1;
            default:           a.size = 3'd2;
        endcase
        return a;
    endfunction

    task automatic check_ret(input string name, input bridge_pkg::cache_ret_t got,
                             input bridge_pkg::cache_ret_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got data %h last %h, expected data %h last %h",
                     name, got.data, got.last, exp.data, exp.last);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input bridge_pkg::axi_ar_t got,
                              input bridge_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic issue_read(input logic is_inst, input logic [31:0] addr,
                              input logic [2:0] xfer);
        bridge_pkg::cache_rd_req_t req;
        bridge_pkg::cache_ret_t    e;
        logic                      rdy;
        int                        n;
        req = '{addr: addr, xfer_type: xfer};
        n = (xfer == `BRIDGE_TYPE_LINE) ? 4 : 1;
        @(negedge aclk);
        if (is_inst) begin
            inst_rd_req = 1'b1;
            inst_rd     = req;
        end else begin
            data_rd_req = 1'b1;
            data_rd     = req;
        end
        do begin
            @(posedge aclk);
            rdy = is_inst ? inst_rd_rdy : data_rd_rdy;
        end while (!rdy);
        exp_ar.push_back(ref_addr(is_inst ? `BRIDGE_ID_INST : `BRIDGE_ID_DATA, addr, xfer));
        for (int i = 0; i < n; i++) begin   // Snapshot at acceptance
            e.data = ref_read(addr + 32'(4 * i));
            e.last = (i == n - 1);
            if (is_inst) exp_inst.push_back(e);
            else exp_data.push_back(e);
        end
        @(negedge aclk);
        if (is_inst) inst_rd_req = 1'b0;
        else data_rd_req = 1'b0;
    endtask

    task automatic issue_write(input logic [31:0] addr, input logic [2:0] xfer,
                               input logic [3:0] strb, input logic [127:0] data);
        @(negedge aclk);
        data_wr_req = 1'b1;
        data_wr = '{addr: addr, xfer_type: xfer, strb: strb, data: data};
        do @(posedge aclk); while (!data_wr_rdy);
        exp_aw.push_back(ref_addr(`BRIDGE_ID_DATA, addr, xfer));
        if (xfer == `BRIDGE_TYPE_LINE) begin
            for (int i = 0; i < 4; i++) begin
                shadow[addr[11:2] + 10'(i)] = data[i*32 +: 32];
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) shadow[addr[11:2]][k*8 +: 8] = data[k*8 +: 8];
            end
        end
        @(negedge aclk);
        data_wr_req = 1'b0;
    endtask

    task automatic wait_reads_done();
        while (exp_inst.size() != 0 || exp_data.size() != 0) @(posedge aclk);
    endtask

    task automatic wait_write_done();
        do @(posedge aclk); while (!data_wr_rdy);
    endtask

    // Return beat comparison
    always @(posedge aclk) begin
        if (rst_n && inst_ret_valid) begin
            if (exp_inst.size() == 0) begin
                $display("Unexpected beat on the instruction return port");
                errors++;
            end else begin
                check_ret("inst_ret", inst_ret, exp_inst.pop_front());
            end
        end
        if (rst_n && data_ret_valid) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected beat on the data return port");
                errors++;
            end else begin
                check_ret("data_ret", data_ret, exp_data.pop_front());
            end
        end
    end

    // AR, AW and W last on the AXI side
    always @(posedge aclk) begin
        if (rst_n && arvalid && arready) begin
            if (exp_ar.size() == 0) begin
                $display("AR transfer with no read request taken");
                errors++;
            end else begin
                check_addr("ar", ar, exp_ar.pop_front());
            end
        end
        if (rst_n && awvalid && awready) begin
            if (exp_aw.size() == 0) begin
                $display("AW transfer with no write request taken");
                errors++;
            end else begin
                w_len  = exp_aw[0].len;
                w_beat = 0;
                check_addr("aw", aw, exp_aw.pop_front());
            end
        end
        if (rst_n && wvalid && wready) begin
            check_ready("w.last", w.last, w_beat == int'(w_len));
            w_beat++;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d inst and %0d data beats never arrived",
                     cycles, exp_inst.size(), exp_data.size());
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        logic [31:0]  addr;
        logic [127:0] line;
        int           kind;
        void'($urandom(88));
        rst_n = 1'b0;
        inst_rd_req = 1'b0;
        inst_rd = '0;
        data_rd_req = 1'b0;
        data_rd = '0;
        data_wr_req = 1'b0;
        data_wr = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = (i * 32'h0100_0193) ^ 32'hc0de_0000;
        end
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        @(posedge aclk);
        check_ready("arvalid", arvalid, 1'b0);
        check_ready("awvalid", awvalid, 1'b0);
        check_ready("wvalid", wvalid, 1'b0);
        check_ready("rready", rready, 1'b0);
        check_ready("bready", bready, 1'b0);
        check_ready("inst_ret_valid", inst_ret_valid, 1'b0);
        check_ready("data_ret_valid", data_ret_valid, 1'b0);
        check_ready("inst_rd_rdy", inst_rd_rdy, 1'b1);
        check_ready("data_rd_rdy", data_rd_rdy, 1'b1);
        check_ready("data_wr_rdy", data_wr_rdy, 1'b1);

        issue_read(1'b1, 32'h0000_0040, `BRIDGE_TYPE_LINE);
        wait_reads_done();
        issue_read(1'b0, 32'h0000_0084, `BRIDGE_TYPE_WORD);
        wait_reads_done();
        issue_read(1'b0, 32'h0000_0093, `BRIDGE_TYPE_BYTE);
        wait_reads_done();

        // Line write, then a partial word write with the read racing it
        issue_write(32'h0000_0100, `BRIDGE_TYPE_LINE, 4'b1111,
                    128'h1111_2222_3333_4444_5555_6666_7777_8888);
        wait_write_done();
        issue_write(32'h0000_0104, `BRIDGE_TYPE_WORD, 4'b0110, 128'hdead_beef);
        issue_read(1'b0, 32'h0000_0100, `BRIDGE_TYPE_LINE);
        wait_write_done();
        wait_reads_done();

        fork
            issue_read(1'b1, 32'h0000_0200, `BRIDGE_TYPE_LINE);
            issue_read(1'b0, 32'h0000_0108, `BRIDGE_TYPE_WORD);
        join
        wait_reads_done();

        for (int n = 0; n < 60; n++) begin
            kind = $urandom_range(0, 3);
            addr = {20'd0, 12'($urandom_range(0, 4095))};
            line = {$urandom, $urandom, $urandom, $urandom};
            case (kind)
                0: issue_read(1'b1, {addr[31:4], 4'b0}, `BRIDGE_TYPE_LINE);
                1: issue_read(1'b0, addr, 3'($urandom_range(0, 2)));
                2: issue_write({addr[31:4], 4'b0}, `BRIDGE_TYPE_LINE, 4'b1111, line);
                default: issue_write({addr[31:2], 2'b0}, `BRIDGE_TYPE_WORD,
                                     4'($urandom_range(1, 15)), line);
            endcase
            if (kind >= 2) wait_write_done();
            else wait_reads_done();
        end

        repeat (4) @(posedge aclk);
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/bridge_pkg.sv
verilog/ar_arbiter.sv
verilog/r_router.sv
verilog/w_burst_engine.sv
verilog/cache_axi_bridge.sv
bench/axi_mem_model.sv
bench/tb_bridge.sv

// ==== Makefile ====
# Verilator build and run for the cache to AXI bridge

TOP = tb_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall -f src.f --top-module cache_axi_bridge

clean:
	rm -rf obj_dir
